// File: logic/poker_pkg.sv
package poker_pkg;

    // chip counts wrap modulo 128.
    typedef logic [6:0] chips_t;

    typedef enum logic [1:0] {
        mode_playing = 2'd0,
        mode_cashout = 2'd1,
        mode_freeze  = 2'd2
    } table_mode_e;

    // the order matters, since a round advances by counting up.
    typedef enum logic [1:0] {
        round_preflop = 2'd0,
        round_flop    = 2'd1,
        round_turn    = 2'd2,
        round_river   = 2'd3
    } round_e;

    typedef enum logic {
        player_1 = 1'b0,
        player_2 = 1'b1
    } player_e;

    typedef enum logic [1:0] {
        close_none     = 2'd0,
        close_fold     = 2'd1,
        close_showdown = 2'd2
    } close_e;

    // one chip movement from the betting logic to the ledger.
    // loser is only looked at when close is close_fold.
    typedef struct packed {
        player_e payer;
        chips_t  pay;
        close_e  close;
        player_e loser;
    } ledger_op_t;

    typedef struct packed {
        table_mode_e mode;
        round_e      round;
        player_e     cur_player;
        logic [7:0]  hand_count;
        chips_t      pot;
        chips_t      balance_1;
        chips_t      balance_2;
    } table_status_t;

endpackage

// File: logic/table_control.sv
`timescale 1ns/1ps

module table_control import poker_pkg::*; (
    input  logic        clk,
    input  logic        reset_d,
    input  logic        cashout,
    input  logic        freeze,
    input  round_e      round,
    output table_mode_e mode,
    output logic        betting_enable,
    output logic        session_clear
);

    table_mode_e saved_mode;
    table_mode_e next_mode;
    table_mode_e next_saved_mode;
    logic        next_session_clear;

    always_comb begin
        next_mode          = mode;
        next_saved_mode    = saved_mode;
        next_session_clear = 1'b0;
        case (mode)
            mode_playing: begin
                if (freeze) begin
                    next_mode       = mode_freeze;
                    next_saved_mode = mode_playing;
                end else if (cashout && round == round_preflop) begin
                    next_mode = mode_cashout;
                end
            end
            mode_cashout: begin
                if (freeze) begin
                    next_mode       = mode_freeze;
                    next_saved_mode = mode_cashout;
                end else if (!cashout) begin
                    // leaving cashout starts a fresh session.
                    next_mode          = mode_playing;
                    next_session_clear = 1'b1;
                end
            end
            mode_freeze: begin
                if (!freeze) begin
                    next_mode = saved_mode;
                end
            end
            default: begin
                next_mode = mode_playing;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            mode          <= mode_playing;
            saved_mode    <= mode_playing;
            session_clear <= 1'b0;
        end else begin
            mode          <= next_mode;
            saved_mode    <= next_saved_mode;
            session_clear <= next_session_clear;
        end
    end

    assign betting_enable = (mode == mode_playing);

endmodule

// File: logic/betting_round.sv
`timescale 1ns/1ps

module betting_round import poker_pkg::*; #(
    parameter chips_t RAISE_STEP = 7'd5,
    parameter chips_t BLIND      = 7'd1
) (
    input  logic       clk,
    input  logic       reset_d,
    input  logic       betting_enable,
    input  logic       session_clear,
    input  logic       fold,
    input  logic       call,
    input  logic       raise,
    output round_e     round,
    output player_e    cur_player,
    output logic [7:0] hand_count,
    output ledger_op_t ledger_op
);

    chips_t     open_bet;
    chips_t     committed_1;
    chips_t     committed_2;

    round_e     next_round;
    player_e    next_player;
    logic [7:0] next_hand_count;
    chips_t     next_open_bet;
    chips_t     next_committed_1;
    chips_t     next_committed_2;

    player_e    start_player;
    player_e    next_start;
    player_e    other_player;
    chips_t     committed_cur;
    chips_t     owed;
    chips_t     raised_bet;
    logic       accept;
    logic       do_fold;
    logic       do_call;
    logic       do_raise;
    logic       is_open;
    logic       advance;
    logic       showdown;

    // the start player alternates with every hand played.
    assign start_player  = player_e'(hand_count[0]);
    assign next_start    = player_e'(~hand_count[0]);
    assign other_player  = player_e'(~cur_player);
    assign committed_cur = (cur_player == player_1) ? committed_1 : committed_2;
    assign owed          = open_bet - committed_cur;
    assign raised_bet    = open_bet + RAISE_STEP;
    assign is_open       = (open_bet != '0);

    // fold wins over call and call wins over raise.
    assign accept   = betting_enable && !session_clear;
    assign do_fold  = accept && fold;
    assign do_call  = accept && call && !fold;
    assign do_raise = accept && raise && !fold && !call;

    // a check only ends the round when the second player makes it.
    assign advance  = do_call && (is_open || cur_player != start_player);
    assign showdown = advance && (round == round_river);

    always_comb begin
        ledger_op = '0;
        if (do_fold) begin
            ledger_op.payer = cur_player;
            ledger_op.close = close_fold;
            ledger_op.loser = cur_player;
        end else if (do_call) begin
            ledger_op.payer = cur_player;
            ledger_op.pay   = is_open ? owed : '0;
            ledger_op.close = showdown ? close_showdown : close_none;
        end else if (do_raise) begin
            ledger_op.payer = cur_player;
            ledger_op.pay   = owed + RAISE_STEP;
        end
    end

    always_comb begin
        next_round       = round;
        next_player      = cur_player;
        next_hand_count  = hand_count;
        next_open_bet    = open_bet;
        next_committed_1 = committed_1;
        next_committed_2 = committed_2;
        if (do_fold || showdown) begin
            next_hand_count  = hand_count + 8'd1;
            next_round       = round_preflop;
            next_player      = next_start;
            next_open_bet    = '0;
            next_committed_1 = '0;
            next_committed_2 = '0;
            // after a fold the new start player posts the blind.
            if (do_fold) begin
                next_open_bet = BLIND;
                if (next_start == player_1) begin
                    next_committed_1 = BLIND;
                end else begin
                    next_committed_2 = BLIND;
                end
            end
        end else if (advance) begin
            next_round       = round_e'(round + 2'd1);
            next_player      = start_player;
            next_open_bet    = '0;
            next_committed_1 = '0;
            next_committed_2 = '0;
        end else if (do_call) begin
            next_player = other_player;
        end else if (do_raise) begin
            next_open_bet = raised_bet;
            if (cur_player == player_1) begin
                next_committed_1 = raised_bet;
            end else begin
                next_committed_2 = raised_bet;
            end
            next_player = other_player;
        end
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            round       <= round_preflop;
            cur_player  <= player_1;
            hand_count  <= '0;
            open_bet    <= '0;
            committed_1 <= '0;
            committed_2 <= '0;
        end else if (session_clear) begin
            round       <= round_preflop;
            cur_player  <= player_1;
            hand_count  <= '0;
            open_bet    <= '0;
            committed_1 <= '0;
            committed_2 <= '0;
        end else begin
            round       <= next_round;
            cur_player  <= next_player;
            hand_count  <= next_hand_count;
            open_bet    <= next_open_bet;
            committed_1 <= next_committed_1;
            committed_2 <= next_committed_2;
        end
    end

endmodule

// File: logic/chip_ledger.sv
`timescale 1ns/1ps

module chip_ledger import poker_pkg::*; #(
    parameter chips_t START_BALANCE = 7'd49,
    parameter chips_t BLIND         = 7'd1
) (
    input  logic       clk,
    input  logic       reset_d,
    input  logic       session_clear,
    input  logic       win,
    input  logic       tie,
    input  ledger_op_t ledger_op,
    output chips_t     pot,
    output chips_t     balance_1,
    output chips_t     balance_2
);

    chips_t paid_1;
    chips_t paid_2;
    chips_t pot_paid;
    chips_t half_pot;
    chips_t next_balance_1;
    chips_t next_balance_2;
    chips_t next_pot;

    // the pay leaves the payer first, so a closing operation pays out
    // a pot that already holds it.
    assign paid_1   = (ledger_op.payer == player_1) ? balance_1 - ledger_op.pay : balance_1;
    assign paid_2   = (ledger_op.payer == player_2) ? balance_2 - ledger_op.pay : balance_2;
    assign pot_paid = pot + ledger_op.pay;
    assign half_pot = pot_paid >> 1;

    always_comb begin
        next_balance_1 = paid_1;
        next_balance_2 = paid_2;
        next_pot       = pot_paid;
        case (ledger_op.close)
            close_fold: begin
                if (ledger_op.loser == player_1) begin
                    next_balance_2 = paid_2 + pot_paid;
                end else begin
                    next_balance_1 = paid_1 + pot_paid;
                end
                // the blind of the next hand is not charged to anyone.
                next_pot = BLIND;
            end
            close_showdown: begin
                if (tie) begin
                    // an odd chip is dropped on a split pot.
                    next_balance_1 = paid_1 + half_pot;
                    next_balance_2 = paid_2 + half_pot;
                end else if (win) begin
                    next_balance_1 = paid_1 + pot_paid;
                end else begin
                    next_balance_2 = paid_2 + pot_paid;
                end
                next_pot = '0;
            end
            default: begin
                next_pot = pot_paid;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            balance_1 <= START_BALANCE;
            balance_2 <= START_BALANCE;
            pot       <= '0;
        end else if (session_clear) begin
            balance_1 <= START_BALANCE;
            balance_2 <= START_BALANCE;
            pot       <= '0;
        end else begin
            balance_1 <= next_balance_1;
            balance_2 <= next_balance_2;
            pot       <= next_pot;
        end
    end

endmodule

// File: logic/poker_table.sv
`timescale 1ns/1ps

module poker_table import poker_pkg::*; #(
    parameter chips_t START_BALANCE = 7'd49,
    parameter chips_t RAISE_STEP    = 7'd5,
    parameter chips_t BLIND         = 7'd1
) (
    input  logic          clk,
    input  logic          reset_d,
    input  logic          fold,
    input  logic          call,
    input  logic          raise,
    input  logic          cashout,
    input  logic          freeze,
    input  logic          win,
    input  logic          tie,
    output table_status_t status
);

    table_mode_e mode;
    logic        betting_enable;
    logic        session_clear;
    round_e      round;
    player_e     cur_player;
    logic [7:0]  hand_count;
    ledger_op_t  ledger_op;
    chips_t      pot;
    chips_t      balance_1;
    chips_t      balance_2;

    table_control i_table_control (
        .clk            (clk),
        .reset_d        (reset_d),
        .cashout        (cashout),
        .freeze         (freeze),
        .round          (round),
        .mode           (mode),
        .betting_enable (betting_enable),
        .session_clear  (session_clear)
    );

    betting_round #(
        .RAISE_STEP (RAISE_STEP),
        .BLIND      (BLIND)
    ) i_betting_round (
        .clk            (clk),
        .reset_d        (reset_d),
        .betting_enable (betting_enable),
        .session_clear  (session_clear),
        .fold           (fold),
        .call           (call),
        .raise          (raise),
        .round          (round),
        .cur_player     (cur_player),
        .hand_count     (hand_count),
        .ledger_op      (ledger_op)
    );

    chip_ledger #(
        .START_BALANCE (START_BALANCE),
        .BLIND         (BLIND)
    ) i_chip_ledger (
        .clk           (clk),
        .reset_d       (reset_d),
        .session_clear (session_clear),
        .win           (win),
        .tie           (tie),
        .ledger_op     (ledger_op),
        .pot           (pot),
        .balance_1     (balance_1),
        .balance_2     (balance_2)
    );

    assign status = '{
        mode:       mode,
        round:      round,
        cur_player: cur_player,
        hand_count: hand_count,
        pot:        pot,
        balance_1:  balance_1,
        balance_2:  balance_2
    };

endmodule

// File: verif/poker_table_chk.sv
`timescale 1ns/1ps

module poker_table_chk import poker_pkg::*; (
    input logic        clk,
    input logic        reset_d,
    input logic        betting_enable,
    input logic        session_clear,
    input table_mode_e mode,
    input round_e      round,
    input chips_t      pot,
    input chips_t      balance_1,
    input chips_t      balance_2
);

    a_clear_single: assert property (@(posedge clk) disable iff (reset_d)
        session_clear |=> !session_clear)
        else $error("session clear stayed high for two cycles");

    // with betting off and no clear pending, the ledger sees an empty operation.
    a_ledger_hold: assert property (@(posedge clk) disable iff (reset_d)
        (!betting_enable && !session_clear) |=>
            ($stable(pot) && $stable(balance_1) && $stable(balance_2)))
        else $error("pot or balance changed while betting was disabled");

    a_cashout_preflop: assert property (@(posedge clk) disable iff (reset_d)
        (mode == mode_cashout) |-> (round == round_preflop))
        else $error("cashout mode outside the preflop round");

endmodule

bind poker_table poker_table_chk i_chk (
    .clk            (clk),
    .reset_d        (reset_d),
    .betting_enable (betting_enable),
    .session_clear  (session_clear),
    .mode           (mode),
    .round          (round),
    .pot            (pot),
    .balance_1      (balance_1),
    .balance_2      (balance_2)
);

// File: verif/poker_table_tb.sv
`timescale 1ns/1ps

module poker_table_tb import poker_pkg::*; ();

    localparam chips_t START_BALANCE = 7'd49;
    localparam chips_t RAISE_STEP    = 7'd5;
    localparam chips_t BLIND         = 7'd1;

    logic          clk;
    logic          reset_d;
    logic          fold, call, raise, cashout, freeze, win, tie;
    table_status_t status;

    // the reference model keeps the expected status and the hidden betting registers.
    table_status_t exp_st;
    table_mode_e   m_saved;
    logic          m_clear;
    chips_t        m_open, m_com1, m_com2;
    logic [31:0]   lfsr_state;
    int            errors;
    int            timeouts;

    poker_table #(
        .START_BALANCE (START_BALANCE),
        .RAISE_STEP    (RAISE_STEP),
        .BLIND         (BLIND)
    ) i_dut (
        .clk (clk), .reset_d (reset_d), .fold (fold), .call (call), .raise (raise),
        .cashout (cashout), .freeze (freeze), .win (win), .tie (tie), .status (status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    task automatic check_status(input table_status_t got, input table_status_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s status %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_chips(input chips_t got, input chips_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic model_reset();
        exp_st = '{mode: mode_playing, round: round_preflop, cur_player: player_1,
                   hand_count: 8'd0, pot: '0, balance_1: START_BALANCE,
                   balance_2: START_BALANCE};
        m_saved = mode_playing;
        m_clear = 1'b0;
        m_open  = '0;
        m_com1  = '0;
        m_com2  = '0;
    endtask

    task automatic model_step(input logic f, c, r, co, fz, w, t);
        table_status_t nx;
        table_mode_e   nsaved;
        logic          nclear, closing;
        chips_t        nopen, ncom1, ncom2, pay, com;
        player_e       start, cur, other;
        nx = exp_st;
        nsaved = m_saved;
        nclear = 1'b0;
        nopen = m_open;
        ncom1 = m_com1;
        ncom2 = m_com2;
        closing = 1'b0;
        start = exp_st.hand_count[0] ? player_2 : player_1;
        cur = exp_st.cur_player;
        other = (cur == player_1) ? player_2 : player_1;
        com = (cur == player_1) ? m_com1 : m_com2;
        if (m_clear) begin
            model_reset();
            nx = exp_st;
            nopen = '0;
            ncom1 = '0;
            ncom2 = '0;
        end else if (exp_st.mode == mode_playing && (f || c || r)) begin
            pay = '0;
            if (f) begin
                closing = 1'b1;
            end else if (c) begin
                if (m_open != '0) pay = m_open - com;
                if (m_open == '0 && cur == start) begin
                    nx.cur_player = other;
                end else if (exp_st.round == round_river) begin
                    closing = 1'b1;
                end else begin
                    nx.round = round_e'(exp_st.round + 2'd1);
                    nx.cur_player = start;
                    nopen = '0;
                    ncom1 = '0;
                    ncom2 = '0;
                end
            end else begin
                pay = m_open - com + RAISE_STEP;
                nopen = m_open + RAISE_STEP;
                if (cur == player_1) ncom1 = nopen;
                else ncom2 = nopen;
                nx.cur_player = other;
            end
            if (cur == player_1) nx.balance_1 = nx.balance_1 - pay;
            else nx.balance_2 = nx.balance_2 - pay;
            nx.pot = exp_st.pot + pay;
            if (closing) begin
                if (f) begin
                    if (cur == player_1) nx.balance_2 = nx.balance_2 + nx.pot;
                    else nx.balance_1 = nx.balance_1 + nx.pot;
                    nx.pot = BLIND;
                end else begin
                    if (t) begin
                        nx.balance_1 = nx.balance_1 + (nx.pot >> 1);
                        nx.balance_2 = nx.balance_2 + (nx.pot >> 1);
                    end else if (w) begin
                        nx.balance_1 = nx.balance_1 + nx.pot;
                    end else begin
                        nx.balance_2 = nx.balance_2 + nx.pot;
                    end
                    nx.pot = '0;
                end
                nx.hand_count = exp_st.hand_count + 8'd1;
                nx.round = round_preflop;
                nx.cur_player = nx.hand_count[0] ? player_2 : player_1;
                nopen = f ? BLIND : '0;
                ncom1 = (f && nx.cur_player == player_1) ? BLIND : '0;
                ncom2 = (f && nx.cur_player == player_2) ? BLIND : '0;
            end
        end
        case (exp_st.mode)
            mode_playing: begin
                if (fz) begin
                    nx.mode = mode_freeze;
                    nsaved = mode_playing;
                end else if (co && exp_st.round == round_preflop) begin
                    nx.mode = mode_cashout;
                end
            end
            mode_cashout: begin
                if (fz) begin
                    nx.mode = mode_freeze;
                    nsaved = mode_cashout;
                end else if (!co) begin
                    nx.mode = mode_playing;
                    nclear = 1'b1;
                end
            end
            default: begin
                if (!fz) nx.mode = m_saved;
            end
        endcase
        exp_st = nx;
        m_saved = nsaved;
        m_clear = nclear;
        m_open = nopen;
        m_com1 = ncom1;
        m_com2 = ncom2;
    endtask

    // drive one cycle of inputs, advance the model and compare after the edge.
    task automatic step(input logic f, c, r, co, fz, w, t);
        fold = f;
        call = c;
        raise = r;
        cashout = co;
        freeze = fz;
        win = w;
        tie = t;
        model_step(f, c, r, co, fz, w, t);
        @(posedge clk);
        #1;
        check_status(status, exp_st, "cycle");
    endtask

    task automatic random_step(input logic co, input logic fz);
        logic f, c, r, w, t;
        f = next_bit() & next_bit() & next_bit() & next_bit();
        c = next_bit();
        r = next_bit() & next_bit();
        w = next_bit();
        t = next_bit() & next_bit();
        step(f, c, r, co, fz, w, t);
    endtask

    task automatic wait_for_mode(input table_mode_e target, input logic co, input logic fz);
        int n;
        n = 0;
        while (status.mode != target && n < 20) begin
            step(1'b0, 1'b0, 1'b0, co, fz, 1'b0, 1'b0);
            n++;
        end
        if (status.mode != target) begin
            timeouts++;
            $display("timeout: table mode did not reach %s within 20 cycles", target.name());
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        lfsr_state = 32'h658d;
        {fold, call, raise, cashout, freeze, win, tie} = '0;
        reset_d = 1'b1;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        reset_d = 1'b0;
        check_status(status, exp_st, "after reset");
        check_chips(status.balance_1, START_BALANCE, "balance_1 after reset");

        // player_1 raises and player_2 folds, so the raise comes back.
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        check_chips(status.pot, BLIND, "pot after fold");
        check_chips(status.balance_1, START_BALANCE, "balance_1 after fold");
        check_chips(status.balance_2, START_BALANCE, "balance_2 after fold");

        repeat (500) random_step(1'b0, 1'b0);

        wait_for_mode(mode_freeze, 1'b0, 1'b1);
        repeat (12) random_step(1'b0, 1'b1);
        wait_for_mode(mode_playing, 1'b0, 1'b0);

        // a fold then a call leaves the flop, where cashout is refused.
        step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_for_mode(mode_cashout, 1'b1, 1'b0);
        repeat (6) random_step(1'b1, 1'b0);
        wait_for_mode(mode_freeze, 1'b1, 1'b1);
        repeat (6) random_step(1'b1, 1'b1);
        wait_for_mode(mode_cashout, 1'b1, 1'b0);
        step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        check_chips(status.balance_1, START_BALANCE, "balance_1 after cashout");
        check_chips(status.balance_2, START_BALANCE, "balance_2 after cashout");
        check_chips(status.pot, '0, "pot after cashout");

        repeat (300) random_step(1'b0, 1'b0);

        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: poker_table.f
logic/poker_pkg.sv
logic/table_control.sv
logic/betting_round.sv
logic/chip_ledger.sv
logic/poker_table.sv
verif/poker_table_chk.sv
verif/poker_table_tb.sv

// File: Makefile
TOP := poker_table_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f poker_table.f --top-module $(TOP) \
		--Mdir obj_dir -o sim

run: build
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" sim.log; then echo "simulation incomplete"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f poker_table.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
